// ==== ddr_model_pkg.sv ====
// ==================================================
// Memory is 1024 words, upper address bits wrap
// Burst length of zero is served as one beat
// ==================================================
package ddr_model_pkg;

    // Data path
    localparam int DATA_W   = 64;
    localparam int BE_W     = DATA_W / 8;

    // External address as seen on the port, and the modelled part of it
    localparam int ADDR_W    = 29;
    localparam int MEM_AW    = 10;
    localparam int MEM_WORDS = 1 << MEM_AW;

    // Burst length field
    localparam int BURST_W  = 8;

    // Free-running accept window with one slot per 2**WINDOW_W cycles
    localparam int WINDOW_W = 5;

    // Acceptance to first read beat
    localparam int READ_LAT = 16;
    localparam int LAT_W    = $clog2(READ_LAT);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ_WAIT,
        ST_READ,
        ST_WRITE
    } burst_state_e;

    // Request as driven by the requester
    typedef struct packed {
        logic               rd;
        logic               we;
        logic [ADDR_W-1:0]  addr;
        logic [BURST_W-1:0] burstcnt;
    } ddr_req_t;

    // One write beat
    typedef struct packed {
        logic [DATA_W-1:0] din;
        logic [BE_W-1:0]   be;
    } ddr_wdata_t;

endpackage

// ==== ddr_burst_fsm.sv ====
// ==================================================
// Accepts only in idle on an open window slot
// ==================================================
module ddr_burst_fsm (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ddr_model_pkg::ddr_req_t req,
    input  logic                    window_zero,
    input  logic                    lat_done,
    input  logic                    last_beat,
    output logic                    start_read,
    output logic                    start_write,
    output logic                    beat_en,
    output logic                    beat_write,
    output logic                    busy,
    output logic                    dout_ready
);
    import ddr_model_pkg::*;

    burst_state_e state;
    burst_state_e state_next;
    logic         accept;

    // Busy drops only on an idle window slot
    assign busy   = !(state == ST_IDLE && window_zero);
    assign accept = !busy && (req.rd || req.we);

    // Read wins if both are raised by mistake
    assign start_read  = accept && req.rd;
    assign start_write = accept && req.we && !req.rd;

    assign beat_en    = (state == ST_READ) || (state == ST_WRITE);
    assign beat_write = (state == ST_WRITE);
    assign dout_ready = (state == ST_READ);

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (start_read) begin
                    state_next = ST_READ_WAIT;
                end else if (start_write) begin
                    state_next = ST_WRITE;
                end
            end
            ST_READ_WAIT: begin
                if (lat_done) begin
                    state_next = ST_READ;
                end
            end
            ST_READ, ST_WRITE: begin
                if (last_beat) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Port stays closed for the whole read latency
    assert property (@(posedge clk) disable iff (!rst_n)
        start_read |=> busy [*READ_LAT]);

    // First read beat appears exactly READ_LAT cycles after acceptance
    assert property (@(posedge clk) disable iff (!rst_n)
        start_read |-> ##(READ_LAT + 1) $rose(dout_ready));

endmodule

// ==== ddr_burst_timer.sv ====
// ==================================================
// Window counter starts at one, so busy is high out of reset
// ==================================================
module ddr_burst_timer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start_read,
    input  logic                              start_write,
    input  logic                              beat_en,
    input  logic [ddr_model_pkg::BURST_W-1:0] burstcnt,
    output logic                              window_zero,
    output logic                              lat_done,
    output logic                              last_beat
);
    import ddr_model_pkg::*;

    logic [WINDOW_W-1:0] win_cnt;
    logic [LAT_W-1:0]    lat_cnt;
    logic                lat_run;
    logic [BURST_W-1:0]  beat_cnt;

    assign window_zero = (win_cnt == '0);
    assign lat_done    = lat_run && (lat_cnt == '0);
    assign last_beat   = (beat_cnt == BURST_W'(1));

    // Free-running accept window
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_cnt <= WINDOW_W'(1);
        end else begin
            win_cnt <= win_cnt + 1'b1;
        end
    end

    // Read latency countdown with a one-cycle done pulse at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lat_cnt <= '0;
            lat_run <= 1'b0;
        end else if (start_read) begin
            lat_cnt <= LAT_W'(READ_LAT - 1);
            lat_run <= 1'b1;
        end else if (lat_run) begin
            if (lat_cnt == '0) begin
                lat_run <= 1'b0;
            end else begin
                lat_cnt <= lat_cnt - 1'b1;
            end
        end
    end

    // Beats left in the burst where zero length counts as one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (start_read || start_write) begin
            beat_cnt <= (burstcnt == '0) ? BURST_W'(1) : burstcnt;
        end else if (beat_en) begin
            beat_cnt <= beat_cnt - 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        beat_en |-> beat_cnt != '0);

endmodule

// ==== ddr_burst_mem.sv ====
// ==================================================
// Contents start at zero; burst address wraps at the top
// ==================================================
module ddr_burst_mem (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             load,
    input  logic [ddr_model_pkg::MEM_AW-1:0] addr,
    input  logic                             beat_en,
    input  logic                             beat_write,
    input  ddr_model_pkg::ddr_wdata_t        wr,
    output logic [ddr_model_pkg::DATA_W-1:0] dout
);
    import ddr_model_pkg::*;

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [MEM_AW-1:0] areg;
    logic [MEM_AW-1:0] areg_next;

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // Address the burst will be at after this edge
    always_comb begin
        areg_next = areg;
        if (load) begin
            areg_next = addr;
        end else if (beat_en) begin
            areg_next = areg + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            areg <= '0;
        end else begin
            areg <= areg_next;
        end
    end

    // Byte-masked write of the current beat
    always_ff @(posedge clk) begin
        if (beat_en && beat_write) begin
            for (int b = 0; b < BE_W; b++) begin
                if (wr.be[b]) begin
                    mem[areg][8*b +: 8] <= wr.din[8*b +: 8];
                end
            end
        end
    end

    // Read one word ahead so data lines up with the ready flag
    always_ff @(posedge clk) begin
        dout <= mem[areg_next];
    end

endmodule

// ==== ddr_model_top.sv ====
// ==================================================
// Requester must hold rd or we until accepted
// ==================================================
module ddr_model_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  ddr_model_pkg::ddr_req_t          req,
    input  ddr_model_pkg::ddr_wdata_t        wr,
    output logic                             busy,
    output logic [ddr_model_pkg::DATA_W-1:0] dout,
    output logic                             dout_ready
);
    import ddr_model_pkg::*;

    logic start_read;
    logic start_write;
    logic beat_en;
    logic beat_write;
    logic window_zero;
    logic lat_done;
    logic last_beat;

    ddr_burst_fsm u_fsm (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .req         ( req         ),
        .window_zero ( window_zero ),
        .lat_done    ( lat_done    ),
        .last_beat   ( last_beat   ),
        .start_read  ( start_read  ),
        .start_write ( start_write ),
        .beat_en     ( beat_en     ),
        .beat_write  ( beat_write  ),
        .busy        ( busy        ),
        .dout_ready  ( dout_ready  )
    );

    ddr_burst_timer u_timer (
        .clk         ( clk          ),
        .rst_n       ( rst_n        ),
        .start_read  ( start_read   ),
        .start_write ( start_write  ),
        .beat_en     ( beat_en      ),
        .burstcnt    ( req.burstcnt ),
        .window_zero ( window_zero  ),
        .lat_done    ( lat_done     ),
        .last_beat   ( last_beat    )
    );

    // Only the low address bits are modelled
    ddr_burst_mem u_mem (
        .clk        ( clk                       ),
        .rst_n      ( rst_n                     ),
        .load       ( start_read || start_write ),
        .addr       ( req.addr[MEM_AW-1:0]      ),
        .beat_en    ( beat_en                   ),
        .beat_write ( beat_write                ),
        .wr         ( wr                        ),
        .dout       ( dout                      )
    );

endmodule

// ==== tb_ddr_model.sv ====
// ==================================================
// Reads ddr_patterns.txt from the project root
// Outputs sampled on the falling edge
// ==================================================
module tb_ddr_model;
    timeunit 1ns;
    timeprecision 100ps;

    import ddr_model_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int SEED       = 79296;
    localparam int WINDOW     = 1 << WINDOW_W;

    logic              clk;
    logic              rst_n;
    ddr_req_t          req;
    ddr_wdata_t        wr;
    logic              busy;
    logic [DATA_W-1:0] dout;
    logic              dout_ready;

    // Records and their beats as read from the pattern file
    logic              rec_is_read [$];
    logic [ADDR_W-1:0] rec_addr [$];
    int                rec_len [$];
    int                rec_first [$];
    logic [DATA_W-1:0] beat_data [$];
    logic [BE_W-1:0]   beat_be [$];
    int                total_beats;

    int     errors;
    int     checks;
    int     cyc;
    int     last_low;
    longint timeout_ns;

    ddr_model_top dut (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .req        ( req        ),
        .wr         ( wr         ),
        .busy       ( busy       ),
        .dout       ( dout       ),
        .dout_ready ( dout_ready )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic expect_flag(input string name, input logic exp, input logic act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("** Error: %s expected %h, got %h at %0t ns", name, exp, act, $time);
        end
    endtask

    task automatic compare_word(input string name, input logic [DATA_W-1:0] exp,
                                input logic [DATA_W-1:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("** Error: %s expected %h, got %h at %0t ns", name, exp, act, $time);
        end
    endtask

    // Busy slots come from a free-running counter, so any two are a whole window apart
    always @(negedge clk) begin
        if (rst_n && !busy) begin
            if (last_low >= 0) begin
                checks++;
                assert ((cyc - last_low) % WINDOW == 0) else begin
                    errors++;
                    $display("Busy low %0d cycles after the previous slot, not a multiple of %0d",
                             cyc - last_low, WINDOW);
                end
            end
            last_low = cyc;
        end
    end

    task automatic load_patterns();
        int                fd;
        int                n;
        int                c;
        int                k;
        int                len;
        string             tok;
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] d;
        logic [BE_W-1:0]   b;
        fd = $fopen("ddr_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file ddr_patterns.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", tok);
            if (n != 1) begin
                break;
            end
            if (tok == "#") begin
                c = $fgetc(fd);
                while (c != 10 && c != -1) begin
                    c = $fgetc(fd);
                end
            end else if (tok == "W" || tok == "R") begin
                n = $fscanf(fd, "%h %h", a, len);
                rec_is_read.push_back(tok == "R");
                rec_addr.push_back(a);
                rec_len.push_back(len);
                rec_first.push_back(beat_data.size());
                total_beats += len;
                for (k = 0; k < len; k++) begin
                    b = '0;
                    if (tok == "W") begin
                        n = $fscanf(fd, "%h %h", d, b);
                    end else begin
                        n = $fscanf(fd, "%h", d);
                    end
                    beat_data.push_back(d);
                    beat_be.push_back(b);
                end
            end else begin
                $display("Unknown record type %s in the pattern file", tok);
                errors++;
                break;
            end
        end
        $fclose(fd);
    endtask

    // Returns on the rising edge that accepts the request
    task automatic issue_request(input logic is_read, input logic [ADDR_W-1:0] addr,
                                 input int len);
        ddr_req_t r;
        r.rd       = is_read;
        r.we       = !is_read;
        r.addr     = addr;
        r.burstcnt = BURST_W'(len);
        @(posedge clk);
        req <= r;
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
        @(posedge clk);
        req <= '0;
    endtask

    task automatic write_burst(input int i);
        ddr_wdata_t w;
        int         k;
        issue_request(1'b0, rec_addr[i], rec_len[i]);
        for (k = 0; k < rec_len[i]; k++) begin
            if (k > 0) begin
                @(posedge clk);
            end
            w.din = beat_data[rec_first[i] + k];
            w.be  = beat_be[rec_first[i] + k];
            wr <= w;
            @(negedge clk);
            expect_flag("busy", 1'b1, busy);
        end
        @(posedge clk);
        wr <= '0;
    endtask

    task automatic read_burst(input int i);
        int j;
        int k;
        issue_request(1'b1, rec_addr[i], rec_len[i]);
        // No data during the latency
        for (j = 0; j < READ_LAT; j++) begin
            @(negedge clk);
            expect_flag("busy", 1'b1, busy);
            expect_flag("dout_ready", 1'b0, dout_ready);
        end
        for (k = 0; k < rec_len[i]; k++) begin
            @(negedge clk);
            expect_flag("busy", 1'b1, busy);
            expect_flag("dout_ready", 1'b1, dout_ready);
            compare_word("dout", beat_data[rec_first[i] + k], dout);
        end
        @(negedge clk);
        expect_flag("dout_ready", 1'b0, dout_ready);
    endtask

    initial begin
        wait (timeout_ns > 0);
        #(timeout_ns);
        $display("Watchdog expired after %0d ns with bursts still pending", timeout_ns);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int idle;
        int i;
        clk         = 1'b0;
        rst_n       = 1'b0;
        req         = '0;
        wr          = '0;
        errors      = 0;
        checks      = 0;
        cyc         = 0;
        last_low    = -1;
        timeout_ns  = 0;
        total_beats = 0;
        void'($urandom(SEED));
        load_patterns();
        timeout_ns = longint'(total_beats + rec_len.size() * (READ_LAT + 40)) * CLK_PERIOD;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        expect_flag("busy", 1'b1, busy);
        expect_flag("dout_ready", 1'b0, dout_ready);

        for (i = 0; i < rec_len.size(); i++) begin
            idle = $urandom_range(5, 0);
            repeat (idle) @(posedge clk);
            if (rec_is_read[i]) begin
                read_burst(i);
            end else begin
                write_burst(i);
            end
        end
        repeat (2) @(posedge clk);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== ddr_patterns.txt ====
# W addr len, then one line per beat: write data, byte enables
# R addr len, then one line per beat: expected read word
R 010 2
0000000000000000
0000000000000000
W 100 3
1111111111111111 ff
2222222222222222 ff
3333333333333333 ff
R 100 3
1111111111111111
2222222222222222
3333333333333333
W 101 2
aaaaaaaaaaaaaaaa 0f
bbbbbbbbbbbbbbbb f0
R 100 3
1111111111111111
22222222aaaaaaaa
bbbbbbbb33333333
W 040003fe 3
0123456789abcdef ff
fedcba9876543210 ff
5a5a5a5a5a5a5a5a ff
R 3fd 4
0000000000000000
0123456789abcdef
fedcba9876543210
5a5a5a5a5a5a5a5a
W 000 1
ffffffffffffffff 81
R 3ff 2
fedcba9876543210
ff5a5a5a5a5a5aff

// ==== sources.f ====
ddr_model_pkg.sv
ddr_burst_fsm.sv
ddr_burst_timer.sv
ddr_burst_mem.sv
ddr_model_top.sv
tb_ddr_model.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator and run from the project root
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal \
        -f sources.f --top-module tb_ddr_model -o sim_ddr_model \
    && ./obj_dir/sim_ddr_model | tee /dev/stderr \
        | grep -q "Simulation finished: PASS" \
    && echo "run_sim: passed" \
    || { echo "run_sim: failed"; exit 1; }
